// ==== verilog/icache_config.svh ====
/*
  Geometry of the direct-mapped instruction cache.
  Include in every RTL file that sizes a port, an array or an address field.
*/
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ========================================
// word and address
// ========================================
// instruction word and address share one width
`define DATA_BITS 32

// ========================================
// line organisation
// ========================================
// number of lines, direct mapped
`define CACHE_LINES 16
// line index field
`define CACHE_INDEX_BITS 4
// words per line, one data bank each
`define LINE_WORDS 4
// word offset inside the line
`define OFFSET_BITS 2
// byte offset inside the word, always zero on fetch
`define BYTE_BITS 2

// tag is whatever is left above index, offset and byte
`define CACHE_TAG_BITS (`DATA_BITS - `CACHE_INDEX_BITS - `OFFSET_BITS - `BYTE_BITS)

`endif

// ==== verilog/icache_pkg.sv ====
/*
  Shared type for the instruction cache.
  Import with icache_pkg::* in any module that looks into a fetch address.
*/
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

  // ========================================
  // cache address
  // ========================================
  // the same 32-bit word seen two ways:
  // raw word on the core and wishbone ports,
  // split fields for arrays, compare and refill counter
  typedef union packed {
    // raw view
    logic [`DATA_BITS-1:0] word;
    // field view, msb first
    struct packed {
      // compared against the stored tag
      logic [`CACHE_TAG_BITS-1:0]   tag;
      // selects the line
      logic [`CACHE_INDEX_BITS-1:0] index;
      // selects the word bank
      logic [`OFFSET_BITS-1:0]      offset;
      // byte inside the word
      logic [`BYTE_BITS-1:0]        byte_off;
    } f;
  } cache_addr_u;

endpackage

`default_nettype wire

// ==== verilog/tag_array.sv ====
/*
  Tag store with one valid bit per line. Read is registered, so rd_tag and
  rd_valid belong to the index presented one cycle earlier.
*/
`default_nettype none

`include "icache_config.svh"

module tag_array (
  input  logic                          clk,
  input  logic                          rst,
  // lookup side
  input  logic [`CACHE_INDEX_BITS-1:0] read_index,
  // fill side
  input  logic                          write_en,
  input  logic [`CACHE_INDEX_BITS-1:0] write_index,
  input  logic [`CACHE_TAG_BITS-1:0]   write_tag,
  // registered read result
  output logic [`CACHE_TAG_BITS-1:0]   rd_tag,
  output logic                          rd_valid
);

  // tag storage, contents only matter once valid
  logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_LINES];
  // one bit per line
  logic [`CACHE_LINES-1:0]    valid;

  // valid bits, the only thing invalidated
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (write_en) begin
      // a fill always makes the line usable
      valid[write_index] <= 1'b1;
    end
  end

  // tag write, no reset needed
  always_ff @(posedge clk) begin
    if (write_en) begin
      tags[write_index] <= write_tag;
    end
  end

  // ========================================
  // synchronous read port
  // ========================================
  always_ff @(posedge clk) begin
    rd_tag <= tags[read_index];
  end

  // valid read is cleared with the array
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= valid[read_index];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/data_bank.sv ====
/*
  One word position of every cache line. The top level builds one bank per
  word offset; refill writes it, lookup reads it a cycle after the index.
*/
`default_nettype none

`include "icache_config.svh"

module data_bank (
  input  logic                          clk,
  // shared by read and write, muxed at top level
  input  logic [`CACHE_INDEX_BITS-1:0] index,
  // write strobe from refill
  input  logic                          we,
  input  logic [`DATA_BITS-1:0]        wdata,
  // registered read word
  output logic [`DATA_BITS-1:0]        rdata
);

  // word storage for all lines
  logic [`DATA_BITS-1:0] mem [`CACHE_LINES];

  // ========================================
  // single port, write then registered read
  // ========================================
  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
  end

  // read returns old data on a write cycle
  // nobody looks at it during refill anyway
  always_ff @(posedge clk) begin
    rdata <= mem[index];
  end

endmodule

`default_nettype wire

// ==== verilog/hit_select.sv ====
/*
  Combinational hit check and word pick. Compares the stored tag with the
  registered request address and selects the bank named by its offset.
*/
`default_nettype none

`include "icache_config.svh"

module hit_select
  import icache_pkg::*;
(
  // from tag_array, one cycle after lookup index
  input  logic [`CACHE_TAG_BITS-1:0]                 rd_tag,
  input  logic                                        rd_valid,
  // all banks of the addressed line
  input  logic [`LINE_WORDS-1:0][`DATA_BITS-1:0]     bank_words,
  // registered request address
  input  cache_addr_u                                 req_addr,
  // result
  output logic                                        hit,
  output logic [`DATA_BITS-1:0]                      word
);

  // tag compare on field view
  logic tag_match;

  // ========================================
  // hit detect
  // ========================================
  // stale tags after reset are masked by valid
  assign tag_match = (rd_tag == req_addr.f.tag);
  assign hit       = rd_valid && tag_match;

  // ========================================
  // word select
  // ========================================
  // offset picks the bank, byte bits ignored
  // word is meaningless unless hit is high
  assign word = bank_words[req_addr.f.offset];

endmodule

`default_nettype wire

// ==== verilog/refill_unit.sv ====
/*
  Wishbone classic read master for line refill. On start it fetches the
  four words of the miss line in offset order, writes each acknowledged word
  into its bank and pulses done one cycle after the last beat.
*/
`default_nettype none

`include "icache_config.svh"

module refill_unit
  import icache_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  // from controller
  input  logic                          start,
  input  cache_addr_u                   miss_addr,
  // wishbone master
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [`DATA_BITS-1:0]        wb_adr,
  input  logic [`DATA_BITS-1:0]        wb_dat_i,
  input  logic                          wb_ack,
  // to data banks
  output logic [`LINE_WORDS-1:0]       bank_we,
  output logic [`CACHE_INDEX_BITS-1:0] refill_index,
  output logic [`DATA_BITS-1:0]        refill_word,
  // to controller
  output logic                          done
);

  // fsm encoding
  localparam logic [1:0] R_IDLE = 2'd0;
  localparam logic [1:0] R_BUS  = 2'd1;
  localparam logic [1:0] R_GAP  = 2'd2;
  localparam logic [1:0] R_DONE = 2'd3;

  // offset of the final beat
  localparam logic [`OFFSET_BITS-1:0] LAST_BEAT = `OFFSET_BITS'(`LINE_WORDS - 1);

  logic [1:0]              state;
  // also the word offset of the current beat
  logic [`OFFSET_BITS-1:0] beat;
  // line being filled, captured on start
  cache_addr_u             line_addr;
  // bus address of current beat
  cache_addr_u             beat_addr;
  // beat completes this edge
  logic                    beat_ack;

  assign beat_ack = (state == R_BUS) && wb_ack;

  // ========================================
  // beat sequencer
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= R_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (start) begin
            state <= R_BUS;
            beat  <= '0;
          end
        end
        R_BUS: begin
          // hold cyc/stb/adr until slave acks
          if (wb_ack) begin
            beat  <= beat + 1'b1;
            state <= (beat == LAST_BEAT) ? R_DONE : R_GAP;
          end
        end
        // cyc and stb low for one cycle between beats
        R_GAP:   state <= R_BUS;
        // done pulse
        R_DONE:  state <= R_IDLE;
        default: state <= R_IDLE;
      endcase
    end
  end

  // miss line, payload only
  always_ff @(posedge clk) begin
    if ((state == R_IDLE) && start) begin
      line_addr <= miss_addr;
    end
  end

  // ========================================
  // bus outputs
  // ========================================
  // line aligned, offset from counter, byte bits zero
  always_comb begin
    beat_addr            = line_addr;
    beat_addr.f.offset   = beat;
    beat_addr.f.byte_off = '0;
  end

  assign wb_cyc = (state == R_BUS);
  assign wb_stb = (state == R_BUS);
  // read only master
  assign wb_we  = 1'b0;
  assign wb_adr = beat_addr.word;

  // ========================================
  // bank write
  // ========================================
  // ack data goes straight into the bank of its offset
  always_comb begin
    bank_we = '0;
    if (beat_ack) begin
      bank_we[beat] = 1'b1;
    end
  end

  assign refill_index = line_addr.f.index;
  assign refill_word  = wb_dat_i;
  assign done         = (state == R_DONE);

endmodule

`default_nettype wire

// ==== verilog/l1c_inst.sv ====
/*
  Direct-mapped L1 instruction cache, top level. The core fetches through a
  req/wait handshake; misses refill a whole line over wishbone classic.
  Holds the IDLE/LOOKUP/REFILL controller and all array instances.
*/
`default_nettype none

`include "icache_config.svh"

module l1c_inst
  import icache_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // core fetch port
  input  logic                   core_req,
  input  logic [`DATA_BITS-1:0] core_addr,
  output logic                   core_wait,
  output logic [`DATA_BITS-1:0] core_out,
  // wishbone master to memory
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`DATA_BITS-1:0] wb_adr,
  input  logic [`DATA_BITS-1:0] wb_dat_i,
  input  logic                   wb_ack
);

  // controller states
  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_LOOKUP = 2'd1;
  localparam logic [1:0] S_REFILL = 2'd2;

  logic [1:0]                            state;
  // array outputs belong to req_addr
  logic                                  rd_ready;
  // request address held for the whole fetch
  cache_addr_u                           req_addr;
  // array index, lookup or refill
  logic [`CACHE_INDEX_BITS-1:0]         lookup_index;

  // tag array
  logic [`CACHE_TAG_BITS-1:0]           rd_tag;
  logic                                  rd_valid;
  // data banks
  logic [`LINE_WORDS-1:0][`DATA_BITS-1:0] bank_words;
  logic [`LINE_WORDS-1:0]               bank_we;
  // refill unit
  logic                                  refill_start;
  logic                                  refill_done;
  logic [`CACHE_INDEX_BITS-1:0]         refill_index;
  logic [`DATA_BITS-1:0]                refill_word;
  // hit select
  logic                                  hit;
  logic [`DATA_BITS-1:0]                hit_word;
  // fetch answered this cycle
  logic                                  answer;

  // ========================================
  // controller
  // ========================================
  // LOOKUP spends one cycle reading, one cycle comparing
  assign answer       = (state == S_LOOKUP) && rd_ready && hit;
  assign refill_start = (state == S_LOOKUP) && rd_ready && !hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (core_req) begin
            state <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (answer) begin
            state <= S_IDLE;
          end else if (refill_start) begin
            state <= S_REFILL;
          end
        end
        S_REFILL: begin
          // tag written on this same edge, so the retry hits
          if (refill_done) begin
            state <= S_LOOKUP;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // high only in the compare cycle of LOOKUP
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ready <= 1'b0;
    end else begin
      rd_ready <= (state == S_LOOKUP) && !rd_ready;
    end
  end

  // capture address when request accepted
  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && core_req) begin
      req_addr.word <= core_addr;
    end
  end

  // banks follow refill while it runs
  assign lookup_index = (state == S_REFILL) ? refill_index : req_addr.f.index;

  // ========================================
  // core side
  // ========================================
  // low with no request, low in the hit cycle
  assign core_wait = core_req && !answer;
  assign core_out  = hit_word;

  // ========================================
  // arrays
  // ========================================
  tag_array i_tag_array (
    .clk         (clk),
    .rst         (rst),
    .read_index  (lookup_index),
    .write_en    (refill_done),
    .write_index (req_addr.f.index),
    .write_tag   (req_addr.f.tag),
    .rd_tag      (rd_tag),
    .rd_valid    (rd_valid)
  );

  // one bank per word offset
  for (genvar w = 0; w < `LINE_WORDS; w++) begin : g_bank
    data_bank i_data_bank (
      .clk   (clk),
      .index (lookup_index),
      .we    (bank_we[w]),
      .wdata (refill_word),
      .rdata (bank_words[w])
    );
  end

  hit_select i_hit_select (
    .rd_tag     (rd_tag),
    .rd_valid   (rd_valid),
    .bank_words (bank_words),
    .req_addr   (req_addr),
    .hit        (hit),
    .word       (hit_word)
  );

  // ========================================
  // memory side
  // ========================================
  refill_unit i_refill_unit (
    .clk          (clk),
    .rst          (rst),
    .start        (refill_start),
    .miss_addr    (req_addr),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .bank_we      (bank_we),
    .refill_index (refill_index),
    .refill_word  (refill_word),
    .done         (refill_done)
  );

endmodule

`default_nettype wire

// ==== tb/l1c_inst_chk.sv ====
/*
  Protocol checks bound into the instruction cache top level.
  Covers the wishbone master rules and the core wait handshake.
*/
`default_nettype none

`include "icache_config.svh"

module l1c_inst_chk
  import icache_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic                   core_req,
  input logic                   core_wait,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input logic                   wb_we,
  input cache_addr_u            wb_adr,
  input logic                   wb_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench for the closing report
  int fail_count = 0;

  // ========================================
  // wishbone master
  // ========================================
  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) wb_stb |-> wb_cyc)
    else begin
      fail_count++;
      $error("wishbone stb high without cyc");
    end

  // unacked beat keeps strobe and address
  a_adr_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
      fail_count++;
      $error("wishbone address or stb changed before ack");
    end

  // read only master
  a_no_write: assert property (@(posedge clk) !wb_we)
    else begin
      fail_count++;
      $error("wishbone we raised by a read only master");
    end

  // bus idle as reset is released
  a_idle_after_rst: assert property (@(posedge clk) $fell(rst) |-> (!wb_cyc && !wb_stb))
    else begin
      fail_count++;
      $error("wishbone cycle active right after reset");
    end

  // ========================================
  // core handshake
  // ========================================
  // refill only for a pending fetch, core held waiting meanwhile
  a_wait_in_refill: assert property (@(posedge clk) disable iff (rst)
    wb_cyc |-> (core_req && core_wait))
    else begin
      fail_count++;
      $error("wishbone cycle open while the core is not held waiting");
    end

endmodule

bind l1c_inst l1c_inst_chk i_l1c_inst_chk (
  .clk       (clk),
  .rst       (rst),
  .core_req  (core_req),
  .core_wait (core_wait),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_we     (wb_we),
  .wb_adr    (wb_adr),
  .wb_ack    (wb_ack)
);

`default_nettype wire

// ==== tb/l1c_inst_tb.sv ====
/*
  Testbench for the L1 instruction cache. Replays fetches from the vector
  file against a wishbone memory model with random ack delay and checks the
  returned words, the refill beats and the hit latency.
*/
`default_nettype none

`include "icache_config.svh"

module l1c_inst_tb
  import icache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FETCH_TIMEOUT = 200;
  localparam int MAX_LINES     = 1000;
  // hit answered in the second sampled cycle
  localparam int HIT_CYCLES    = 2;
  // bytes per word and per line on the bus
  localparam int WORD_BYTES    = `DATA_BITS / 8;
  localparam int LINE_BYTES    = `LINE_WORDS * WORD_BYTES;

  logic                   clk;
  logic                   rst;
  logic                   core_req;
  logic [`DATA_BITS-1:0] core_addr;
  logic                   core_wait;
  logic [`DATA_BITS-1:0] core_out;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`DATA_BITS-1:0] wb_adr;
  logic [`DATA_BITS-1:0] wb_dat_i;
  logic                   wb_ack;

  // memory model state
  integer      seed = 64306;
  int          ack_delay;
  logic        ack_armed;
  // beat addresses seen during the current fetch
  cache_addr_u beat_q[$];

  // error counters
  int word_errors    = 0;
  int addr_errors    = 0;
  int refill_errors  = 0;
  int count_errors   = 0;
  int level_errors   = 0;
  int timeout_errors = 0;
  int file_errors    = 0;

  l1c_inst i_l1c_inst (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .core_addr (core_addr),
    .core_wait (core_wait),
    .core_out  (core_out),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ========================================
  // memory model
  // ========================================
  // upper half is the inverted low address half
  function automatic logic [`DATA_BITS-1:0] mem_word(input logic [`DATA_BITS-1:0] adr);
    return {~adr[15:0], adr[15:0]};
  endfunction

  // wishbone slave, driven on the falling edge, 0 to 3 wait cycles
  always @(negedge clk) begin
    if (rst) begin
      wb_ack    = 1'b0;
      ack_armed = 1'b0;
    end else if (wb_ack) begin
      // beat taken on the last rising edge
      wb_ack    = 1'b0;
      ack_armed = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!ack_armed) begin
        ack_armed = 1'b1;
        ack_delay = $unsigned($random(seed)) % 4;
      end
      if (ack_delay == 0) begin
        wb_ack   = 1'b1;
        wb_dat_i = mem_word(wb_adr);
        beat_q.push_back(cache_addr_u'(wb_adr));
      end else begin
        ack_delay = ack_delay - 1;
      end
    end
  end

  // ========================================
  // compare tasks
  // ========================================
  task automatic check_word(input logic [`DATA_BITS-1:0] exp, input logic [`DATA_BITS-1:0] got);
    if (got !== exp) begin
      word_errors++;
      $display("MISMATCH at %0t ns: instruction word expected %h got %h", $time, exp, got);
    end
  endtask

  task automatic check_refill_addr(input int beat, input cache_addr_u exp, input cache_addr_u got);
    if (got !== exp) begin
      addr_errors++;
      $display("MISMATCH at %0t ns: beat %0d address expected %h got %h",
               $time, beat, exp.word, got.word);
    end
  endtask

  task automatic check_refill(input logic exp, input logic got);
    if (got !== exp) begin
      refill_errors++;
      $display("MISMATCH at %0t ns: refill flag expected %0b got %0b", $time, exp, got);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int got);
    if (got != exp) begin
      count_errors++;
      $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      level_errors++;
      $display("MISMATCH at %0t ns: %s expected %0b got %0b", $time, what, exp, got);
    end
  endtask

  // ========================================
  // one fetch on the core port
  // ========================================
  // called at a falling edge, returns at a falling edge with core_req low
  task automatic run_fetch(
    input  logic [`DATA_BITS-1:0] addr,
    output logic [`DATA_BITS-1:0] word,
    output int                    cycles,
    output int                    cyc_rises,
    output logic                  timed_out
  );
    logic cyc_prev;
    logic answered;
    beat_q.delete();
    word      = '0;
    cycles    = 0;
    cyc_rises = 0;
    answered  = 1'b0;
    cyc_prev  = wb_cyc;
    core_req  = 1'b1;
    core_addr = addr;
    while (!answered && cycles < FETCH_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      // each refill beat opens a new cycle
      if (wb_cyc && !cyc_prev) begin
        cyc_rises++;
      end
      cyc_prev = wb_cyc;
      if (!core_wait) begin
        answered = 1'b1;
        word     = core_out;
      end
    end
    timed_out = !answered;
    // request held through the completing edge
    @(negedge clk);
    core_req = 1'b0;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int                    fd;
    int                    code;
    int                    n_lines;
    int                    n_fetch;
    int                    refill_exp;
    int                    cycles;
    int                    rises;
    int                    total;
    logic                  timed_out;
    logic                  at_end;
    logic [`DATA_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] exp_word;
    logic [`DATA_BITS-1:0] got_word;
    cache_addr_u           exp_beat;
    string                 skip;
    clk       = 1'b0;
    rst       = 1'b1;
    core_req  = 1'b0;
    core_addr = '0;
    wb_dat_i  = '0;
    wb_ack    = 1'b0;
    ack_armed = 1'b0;
    ack_delay = 0;
    n_lines   = 0;
    n_fetch   = 0;
    timed_out = 1'b0;
    at_end    = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // quiet interfaces after reset
    check_level("core_wait after reset", 1'b0, core_wait);
    check_level("wb_cyc after reset", 1'b0, wb_cyc);
    check_level("wb_stb after reset", 1'b0, wb_stb);

    fd = $fopen("tb/l1c_inst_vectors.txt", "r");
    if (fd == 0) begin
      file_errors++;
      $display("could not open the vector file tb/l1c_inst_vectors.txt");
    end else begin
      while (!timed_out && !at_end && n_lines < MAX_LINES) begin
        n_lines++;
        code = $fscanf(fd, "%h %h %d", addr, exp_word, refill_exp);
        if (code == 3) begin
          n_fetch++;
          run_fetch(addr, got_word, cycles, rises, timed_out);
          if (timed_out) begin
            timeout_errors++;
            $display("timeout: fetch of address %h got no answer within %0d cycles",
                     addr, FETCH_TIMEOUT);
          end else begin
            check_word(exp_word, got_word);
            check_refill(refill_exp != 0, rises != 0);
            if (refill_exp != 0) begin
              check_count("refill beats", `LINE_WORDS, beat_q.size());
              // line aligned, offset order, byte bits zero
              for (int k = 0; k < beat_q.size() && k < `LINE_WORDS; k++) begin
                exp_beat.word = (addr & ~(LINE_BYTES - 1)) + k * WORD_BYTES;
                check_refill_addr(k, exp_beat, beat_q[k]);
              end
            end else begin
              check_count("wishbone beats on hit", 0, beat_q.size());
              check_count("hit latency", HIT_CYCLES, cycles);
            end
            // idle gap between fetches
            @(negedge clk);
            check_level("core_wait without request", 1'b0, core_wait);
          end
        end else if (code < 0) begin
          at_end = 1'b1;
        end else begin
          // comment line, drop the rest of it
          code = $fgets(skip, fd);
        end
      end
      $fclose(fd);
      if (n_fetch == 0) begin
        file_errors++;
        $display("no fetch vectors were read from the vector file");
      end
    end

    total = word_errors + addr_errors + refill_errors + count_errors + level_errors
          + timeout_errors + file_errors + i_l1c_inst.i_l1c_inst_chk.fail_count;
    $display("errors: word %0d, beat address %0d, refill %0d, count %0d, level %0d, %s",
             word_errors, addr_errors, refill_errors, count_errors, level_errors,
             $sformatf("timeout %0d, file %0d, assertion %0d, fetches %0d",
                       timeout_errors, file_errors,
                       i_l1c_inst.i_l1c_inst_chk.fail_count, n_fetch));
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache.f ====
+incdir+verilog
verilog/icache_pkg.sv
verilog/tag_array.sv
verilog/data_bank.sv
verilog/hit_select.sv
verilog/refill_unit.sv
verilog/l1c_inst.sv
tb/l1c_inst_chk.sv
tb/l1c_inst_tb.sv

// ==== tb/l1c_inst_vectors.txt ====
# fetch vectors, one per line: address (hex), expected instruction word (hex),
# refill expected (1 = miss and line refill, 0 = hit); memory word is {~a[15:0], a[15:0]}
00001000 efff1000 1
00001004 effb1004 0
0000100c eff3100c 0
00001008 eff71008 0
00001010 efef1010 1
0000101c efe3101c 0
00002000 dfff2000 1
00002004 dffb2004 0
00001000 efff1000 1
00001014 efeb1014 0
000010f8 ef0710f8 1
000010f0 ef0f10f0 0
00abcd34 32cbcd34 1
00abcd3c 32c3cd3c 0
00abcd30 32cfcd30 0
12345678 a9875678 1
12345670 a98f5670 0
ffff0034 ffcb0034 1
00abcd38 32c7cd38 1
00001008 eff71008 0
0000200c dff3200c 1
0000200c dff3200c 0
